/* Makefile */
VERILATOR ?= verilator
TOP       := ciSubsystemTb
RTL_TOP   := ciSubsystem
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* build.f */
+incdir+hw
hw/or1420CiPkg.sv
hw/ciBus.sv
hw/resetSequencer.sv
hw/swapByteIse.sv
hw/grayscaleIse.sv
hw/profileCounters.sv
hw/ciSubsystem.sv
verification/ciSubsystem_asserts.sv
verification/ciSubsystemTb.sv

/* hw/ciBus.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

interface ciBus;

  logic                      start;
  logic [`CI_ID_WIDTH-1:0]   n;
  or1420CiPkg::ciWord_t      dataA;
  logic [`CI_DATA_WIDTH-1:0] dataB;
  logic                      done;
  logic [`CI_DATA_WIDTH-1:0] result;

  // processor side.
  modport master (
    output start,
    output n,
    output dataA,
    output dataB,
    input  done,
    input  result
  );

  // custom-instruction unit side.
  modport unit (
    input  start,
    input  n,
    input  dataA,
    input  dataB,
    output done,
    output result
  );

endinterface

/* hw/ciSubsystem.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

module ciSubsystem (
  input  logic                      s_systemClock,
  input  logic                      s_pllLocked,
  input  logic                      ciStart,
  input  logic [`CI_ID_WIDTH-1:0]   ciN,
  input  logic [`CI_DATA_WIDTH-1:0] ciDataA,
  input  logic [`CI_DATA_WIDTH-1:0] ciDataB,
  input  logic                      cpuStall,
  input  logic                      busIdle,
  output logic                      ciDone,
  output logic [`CI_DATA_WIDTH-1:0] ciResult,
  output logic                      systemReady
);

  localparam int UNIT_COUNT = 3;

  logic                                      cpuReset;
  logic [UNIT_COUNT-1:0]                     unitDone;
  logic [UNIT_COUNT-1:0][`CI_DATA_WIDTH-1:0] unitResult;

  // connection 0 serves swap, 1 gray and 2 profiling.
  ciBus unitBus [UNIT_COUNT] ();

  resetSequencer resetSeq0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .systemReady  (systemReady),
    .cpuReset     (cpuReset)
  );

  // same instruction goes to every unit.
  for (genvar i = 0; i < UNIT_COUNT; i++) begin : g_fanOut
    assign unitBus[i].start = ciStart;
    assign unitBus[i].n     = ciN;
    assign unitBus[i].dataA = ciDataA;
    assign unitBus[i].dataB = ciDataB;
    assign unitDone[i]      = unitBus[i].done;
    assign unitResult[i]    = unitBus[i].result;
  end

  swapByteIse swapByte0 (
    .ci(unitBus[0])
  );

  grayscaleIse grayscale0 (
    .ci(unitBus[1])
  );

  profileCounters profile0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .cpuReset     (cpuReset),
    .cpuStall     (cpuStall),
    .busIdle      (busIdle),
    .ci           (unitBus[2])
  );

  // idle units drive zero, so an OR merges the answers.
  always_comb begin
    ciResult = '0;
    for (int k = 0; k < UNIT_COUNT; k++) begin
      ciResult = ciResult | unitResult[k];
    end
  end

  assign ciDone = |unitDone;

endmodule

/* hw/grayscaleIse.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

module grayscaleIse (
  ciBus.unit ci
);

  or1420CiPkg::ciWord_t operandA;
  logic                 selected;
  logic [7:0]           redFull;
  logic [7:0]           greenFull;
  logic [7:0]           blueFull;
  logic [15:0]          weightedSum;
  logic [7:0]           grayValue;

  assign operandA = ci.dataA;
  assign selected = ci.start && (ci.n == `CI_ID_GRAY);

  // widen each channel by repeating its top bits.
  assign redFull   = {operandA.pixel.red, operandA.pixel.red[4:2]};
  assign greenFull = {operandA.pixel.green, operandA.pixel.green[5:4]};
  assign blueFull  = {operandA.pixel.blue, operandA.pixel.blue[4:2]};

  // weights add up to 256, so the sum fits 16 bits.
  assign weightedSum = `GRAY_WEIGHT_RED * 16'(redFull) +
                       `GRAY_WEIGHT_GREEN * 16'(greenFull) +
                       `GRAY_WEIGHT_BLUE * 16'(blueFull);

  assign grayValue = weightedSum[15:8];

  assign ci.done   = selected;
  assign ci.result = selected ? {{(`CI_DATA_WIDTH-8){1'b0}}, grayValue} : '0;

endmodule

/* hw/or1420CiPkg.sv */
`include "or1420Ci_consts.svh"

package or1420CiPkg;

  // rgb565 pixel in the low halfword of an operand.
  typedef struct packed {
    logic [`CI_DATA_WIDTH-17:0] unused;
    logic [4:0]                 red;
    logic [5:0]                 green;
    logic [4:0]                 blue;
  } rgb565_t;

  // operand word, seen as bytes or as a pixel.
  typedef union packed {
    logic [`CI_DATA_WIDTH/8-1:0][7:0] bytes;
    rgb565_t                          pixel;
  } ciWord_t;

endpackage

/* hw/or1420Ci_consts.svh */
`ifndef OR1420CI_CONSTS_SVH
`define OR1420CI_CONSTS_SVH

// custom-instruction port widths.
`define CI_ID_WIDTH 8
`define CI_DATA_WIDTH 32

// instruction numbers of the units.
`define CI_ID_SWAP 8'd1
`define CI_ID_PROFILE 8'd11
`define CI_ID_GRAY 8'd62

// top bit of the counter marks release.
`define RESET_COUNT_BITS 5

// luminance weights applied before a shift right by 8.
`define GRAY_WEIGHT_RED 8'd54
`define GRAY_WEIGHT_GREEN 8'd183
`define GRAY_WEIGHT_BLUE 8'd19

`define PROFILE_COUNTERS 3

`endif

/* hw/profileCounters.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

module profileCounters (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  input  logic cpuReset,
  input  logic cpuStall,
  input  logic busIdle,
  ciBus.unit   ci
);

  logic [`PROFILE_COUNTERS-1:0]                     enableReg;
  logic [`PROFILE_COUNTERS-1:0][`CI_DATA_WIDTH-1:0] counterRegs;
  logic [`PROFILE_COUNTERS-1:0]                     countEvent;
  logic                                             selected;
  logic [1:0]                                       readSelect;
  logic [`CI_DATA_WIDTH-1:0]                        readValue;

  // cycles, stall cycles, bus-idle cycles.
  assign countEvent = {busIdle, cpuStall, 1'b1};

  assign selected   = ci.start && (ci.n == `CI_ID_PROFILE) && !cpuReset;
  assign readSelect = ci.dataA[1:0];

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enableReg   <= '0;
      counterRegs <= '0;
    end else if (cpuReset) begin
      enableReg   <= '0;
      counterRegs <= '0;
    end else begin
      for (int k = 0; k < `PROFILE_COUNTERS; k++) begin
        // disable has priority over enable.
        if (selected && ci.dataB[k+4]) begin
          enableReg[k] <= 1'b0;
        end else if (selected && ci.dataB[k]) begin
          enableReg[k] <= 1'b1;
        end
        // clear has priority over counting.
        if (selected && ci.dataB[k+8]) begin
          counterRegs[k] <= '0;
        end else if (enableReg[k] && countEvent[k]) begin
          counterRegs[k] <= counterRegs[k] + 1'b1;
        end
      end
    end
  end

  // read returns the value before this cycle's update.
  always_comb begin
    case (readSelect)
      2'd0:    readValue = counterRegs[0];
      2'd1:    readValue = counterRegs[1];
      2'd2:    readValue = counterRegs[2];
      default: readValue = {{(`CI_DATA_WIDTH-`PROFILE_COUNTERS){1'b0}}, enableReg};
    endcase
  end

  assign ci.done   = selected;
  assign ci.result = selected ? readValue : '0;

endmodule

/* hw/resetSequencer.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReady,
  output logic cpuReset
);

  logic [`RESET_COUNT_BITS-1:0] resetCountReg;

  // counts up once after lock and then holds.
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCountReg <= '0;
    end else if (!resetCountReg[`RESET_COUNT_BITS-1]) begin
      resetCountReg <= resetCountReg + 1'b1;
    end
  end

  assign systemReady = resetCountReg[`RESET_COUNT_BITS-1];
  assign cpuReset    = ~resetCountReg[`RESET_COUNT_BITS-1];

endmodule

/* hw/swapByteIse.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

module swapByteIse (
  ciBus.unit ci
);

  or1420CiPkg::ciWord_t      operandA;
  or1420CiPkg::ciWord_t      swapped;
  logic                      selected;

  assign operandA = ci.dataA;
  assign selected = ci.start && (ci.n == `CI_ID_SWAP);

  always_comb begin
    if (ci.dataB[0]) begin
      // swap inside each halfword.
      swapped.bytes[3] = operandA.bytes[2];
      swapped.bytes[2] = operandA.bytes[3];
      swapped.bytes[1] = operandA.bytes[0];
      swapped.bytes[0] = operandA.bytes[1];
    end else begin
      // full byte reversal.
      swapped.bytes[3] = operandA.bytes[0];
      swapped.bytes[2] = operandA.bytes[1];
      swapped.bytes[1] = operandA.bytes[2];
      swapped.bytes[0] = operandA.bytes[3];
    end
  end

  assign ci.done   = selected;
  assign ci.result = selected ? swapped : '0;

endmodule

/* verification/ciSubsystemTb.sv */
`timescale 1ns/1ps
`include "or1420Ci_consts.svh"

module ciSubsystemTb;

  localparam int READY_EDGES   = 16;
  localparam int READY_TIMEOUT = 64;
  localparam int RANDOM_CYCLES = 4000;

  logic                      s_systemClock;
  logic                      s_pllLocked;
  logic                      ciStart;
  logic [`CI_ID_WIDTH-1:0]   ciN;
  logic [`CI_DATA_WIDTH-1:0] ciDataA;
  logic [`CI_DATA_WIDTH-1:0] ciDataB;
  logic                      cpuStall;
  logic                      busIdle;
  logic                      ciDone;
  logic [`CI_DATA_WIDTH-1:0] ciResult;
  logic                      systemReady;

  // reference model state.
  logic [`CI_DATA_WIDTH-1:0] modelCount [3];
  logic [2:0]                modelEnable;
  logic                      lockRequest;
  int                        lockedEdges;
  int                        waitCycles;
  int                        checkCount;
  int                        mismatchCount;
  int                        otherErrors;

  ciSubsystem dut0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciN          (ciN),
    .ciDataA      (ciDataA),
    .ciDataB      (ciDataB),
    .cpuStall     (cpuStall),
    .busIdle      (busIdle),
    .ciDone       (ciDone),
    .ciResult     (ciResult),
    .systemReady  (systemReady)
  );

  bind ciSubsystem ciSubsystemAsserts asserts0 (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciStart      (ciStart),
    .ciDone       (ciDone),
    .systemReady  (systemReady)
  );

  always #2 s_systemClock = ~s_systemClock;

  function automatic logic [31:0] swapWord(input logic [31:0] a, input logic halfMode);
    if (halfMode) begin
      return {a[23:16], a[31:24], a[7:0], a[15:8]};
    end
    return {a[7:0], a[15:8], a[23:16], a[31:24]};
  endfunction

  function automatic logic [31:0] grayOf(input logic [15:0] pixel);
    int red8;
    int green8;
    int blue8;
    int sum;
    red8   = {pixel[15:11], pixel[15:13]};
    green8 = {pixel[10:5], pixel[10:9]};
    blue8  = {pixel[4:0], pixel[4:2]};
    sum = 54 * red8 + 183 * green8 + 19 * blue8;
    return 32'(sum >> 8);
  endfunction

  function automatic logic [31:0] profileRead(input logic [1:0] sel);
    if (sel == 2'd3) begin
      return {29'd0, modelEnable};
    end
    return modelCount[sel];
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    mismatchCount++;
    $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, expected);
  endtask

  task automatic checkOutputs();
    logic                      expReady;
    logic                      expDone;
    logic [`CI_DATA_WIDTH-1:0] expResult;
    expReady  = s_pllLocked && (lockedEdges >= READY_EDGES);
    expDone   = 1'b0;
    expResult = '0;
    if (ciStart && ciN == `CI_ID_SWAP) begin
      expDone   = 1'b1;
      expResult = swapWord(ciDataA, ciDataB[0]);
    end else if (ciStart && ciN == `CI_ID_GRAY) begin
      expDone   = 1'b1;
      expResult = grayOf(ciDataA[15:0]);
    end else if (ciStart && ciN == `CI_ID_PROFILE && expReady) begin
      expDone   = 1'b1;
      expResult = profileRead(ciDataA[1:0]);
    end
    checkCount++;
    if (systemReady !== expReady) begin
      reportMismatch("systemReady", 32'(systemReady), 32'(expReady));
    end
    if (ciDone !== expDone) begin
      reportMismatch("ciDone", 32'(ciDone), 32'(expDone));
    end
    if (ciResult !== expResult) begin
      reportMismatch("ciResult", ciResult, expResult);
    end
  endtask

  // next state after the coming edge.
  task automatic updateModel();
    logic [2:0] events;
    logic       selected;
    events   = {busIdle, cpuStall, 1'b1};
    selected = ciStart && (ciN == `CI_ID_PROFILE);
    if (!s_pllLocked || lockedEdges < READY_EDGES) begin
      modelCount  = '{default: '0};
      modelEnable = '0;
    end else begin
      for (int k = 0; k < 3; k++) begin
        if (selected && ciDataB[k+8]) begin
          modelCount[k] = '0;
        end else if (modelEnable[k] && events[k]) begin
          modelCount[k] = modelCount[k] + 32'd1;
        end
      end
      for (int k = 0; k < 3; k++) begin
        if (selected && ciDataB[k+4]) begin
          modelEnable[k] = 1'b0;
        end else if (selected && ciDataB[k]) begin
          modelEnable[k] = 1'b1;
        end
      end
    end
    if (s_pllLocked && lockedEdges < READY_EDGES) begin
      lockedEdges++;
    end
  endtask

  task automatic stepCycle(input logic start, input logic [7:0] id,
                           input logic [31:0] a, input logic [31:0] b);
    @(posedge s_systemClock);
    s_pllLocked <= lockRequest;
    ciStart     <= start;
    ciN         <= id;
    ciDataA     <= a;
    ciDataB     <= b;
    cpuStall    <= ($urandom & 1) != 0;
    busIdle     <= ($urandom & 1) != 0;
    @(negedge s_systemClock);
    checkOutputs();
    updateModel();
  endtask

  task automatic randomCycle(input bit profileOnly);
    logic [7:0]  id;
    logic [31:0] a;
    logic [31:0] b;
    logic        start;
    int          pick;
    pick  = int'($urandom % 8);
    start = ($urandom & 1) != 0;
    a     = $urandom;
    b     = $urandom;
    if (profileOnly || pick == 4 || pick == 5) begin
      id = `CI_ID_PROFILE;
      // clear commands stay rare so counters can grow.
      b = b & 32'hffff_f8ff;
      if ($urandom % 8 == 0) begin
        b = b | ($urandom & 32'h0000_0700);
      end
    end else if (pick < 2) begin
      id = `CI_ID_SWAP;
    end else if (pick < 4) begin
      id = `CI_ID_GRAY;
    end else begin
      id = 8'($urandom);
      if (id == `CI_ID_SWAP || id == `CI_ID_GRAY || id == `CI_ID_PROFILE) begin
        id = id ^ 8'h80;
      end
    end
    stepCycle(start, id, a, b);
  endtask

  task automatic finishRun();
    $display("checks %0d, mismatches %0d, other errors %0d",
             checkCount, mismatchCount, otherErrors);
    if (mismatchCount == 0 && otherErrors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'hfdc0_356d));
    s_systemClock = 1'b0;
    s_pllLocked   = 1'b0;
    lockRequest   = 1'b0;
    ciStart       = 1'b0;
    ciN           = '0;
    ciDataA       = '0;
    ciDataB       = '0;
    cpuStall      = 1'b0;
    busIdle       = 1'b0;
    modelCount    = '{default: '0};
    modelEnable   = '0;
    lockedEdges   = 0;
    checkCount    = 0;
    mismatchCount = 0;
    otherErrors   = 0;
    repeat (3) stepCycle(1'b0, '0, '0, '0);
    // swap and gray units never see the processor reset.
    lockRequest = 1'b1;
    waitCycles  = 0;
    while (!systemReady && waitCycles < READY_TIMEOUT) begin
      randomCycle(1'b1);
      waitCycles++;
    end
    if (!systemReady) begin
      otherErrors++;
      $display("timeout: systemReady did not rise within %0d cycles", READY_TIMEOUT);
    end else begin
      if (waitCycles != READY_EDGES + 1) begin
        otherErrors++;
        $display("systemReady rose after %0d edges instead of %0d",
                 waitCycles - 1, READY_EDGES);
      end
      repeat (RANDOM_CYCLES) randomCycle(1'b0);
    end
    finishRun();
  end

endmodule

/* verification/ciSubsystem_asserts.sv */
`timescale 1ns/1ps

module ciSubsystemAsserts (
  input logic s_systemClock,
  input logic s_pllLocked,
  input logic ciStart,
  input logic ciDone,
  input logic systemReady
);

  // a unit only answers inside an instruction cycle.
  doneNeedsStart: assert property (
    @(posedge s_systemClock) ciDone |-> ciStart
  ) else $error("ciDone high without ciStart");

  // no answer while the processor side is held in reset.
  noDoneBeforeReady: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !systemReady |-> !ciDone
  ) else $error("ciDone high while systemReady is low");

  // release is permanent until lock is lost.
  readyHolds: assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !$fell(systemReady)
  ) else $error("systemReady fell while s_pllLocked is high");

endmodule
